// ==== frontend_top.f ====
verilog/frontend_pkg.sv
verilog/fetch_id_if.sv
verilog/fetch_buf.sv
verilog/fifo_id_reg.sv
verilog/id_predecode.sv
verilog/frontend_top.sv
testbench/frontend_chk.sv
testbench/tb_frontend_top.sv

// ==== testbench/frontend_chk.sv ====
`timescale 1ns/1ps

module frontend_chk import frontend_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        flush,
    input logic                        fetch_ready,
    input logic                        id_valid,
    input logic [XLEN-1:0]             id_inst0,
    input logic [$clog2(FIFO_DEPTH):0] count  // buffer occupancy
);

    // buffer accepts whenever it has a free slot, and never overfills
    ready_when_room: assert property (
        @(posedge clk) disable iff (!rst_n)
        (count <= FIFO_DEPTH) && (fetch_ready == (count < FIFO_DEPTH))
    ) else $error("fetch_ready %b with %0d of %0d entries used", fetch_ready, count,
                  FIFO_DEPTH);

    flush_kills_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !id_valid
    ) else $error("id_valid still high one cycle after flush");

    // an invalid slot always shows the bubble word
    bubble_is_nop: assert property (
        @(posedge clk) disable iff (!rst_n)
        !id_valid |-> (id_inst0 == INST_NOP)
    ) else $error("id_valid low but id_inst0 is %h", id_inst0);

endmodule

// ==== testbench/tb_frontend_top.sv ====
`timescale 1ns/1ps

module tb_frontend_top import frontend_pkg::*; ();

    localparam int DEPTH = 4;
    localparam int PKT_W = 3 * XLEN + EXCP_W;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              flush;
    logic              fetch_valid;
    logic [XLEN-1:0]   fetch_pc;
    logic [XLEN-1:0]   fetch_inst0;
    logic [XLEN-1:0]   fetch_inst1;
    logic [EXCP_W-1:0] fetch_excp;
    logic              id_allowin;
    logic              fetch_ready;
    logic              id_valid;
    logic [XLEN-1:0]   id_pc;
    logic [XLEN-1:0]   id_inst0;
    logic [XLEN-1:0]   id_inst1;
    logic [EXCP_W-1:0] id_excp;
    logic [CLS_W-1:0]  id_class0;
    logic [CLS_W-1:0]  id_class1;
    logic [4:0]        id_rd0;
    logic [4:0]        id_rd1;
    logic [XLEN-1:0]   id_imm0;
    logic [XLEN-1:0]   id_imm1;

    logic [PKT_W-1:0] model_q[$];  // packets held in the buffer
    logic              exp_ready;
    logic              exp_valid;
    logic [XLEN-1:0]   exp_pc;
    logic [XLEN-1:0]   exp_inst0;
    logic [XLEN-1:0]   exp_inst1;
    logic [EXCP_W-1:0] exp_excp;

    logic [31:0] lcg_state = 32'd79374;
    string       cur_test;
    int          err_count;
    int          err_start;
    int          tests_ok;
    int          tests_bad;

    frontend_top #(
        .FIFO_DEPTH (DEPTH)
    ) i_frontend_top (
        .clk(clk), .rst_n(rst_n), .flush(flush), .fetch_valid(fetch_valid),
        .fetch_pc(fetch_pc), .fetch_inst0(fetch_inst0), .fetch_inst1(fetch_inst1),
        .fetch_excp(fetch_excp), .id_allowin(id_allowin), .fetch_ready(fetch_ready),
        .id_valid(id_valid), .id_pc(id_pc), .id_inst0(id_inst0), .id_inst1(id_inst1),
        .id_excp(id_excp), .id_class0(id_class0), .id_class1(id_class1),
        .id_rd0(id_rd0), .id_rd1(id_rd1), .id_imm0(id_imm0), .id_imm1(id_imm1)
    );

    bind frontend_top frontend_chk #(.FIFO_DEPTH(FIFO_DEPTH)) u_frontend_chk (
        .clk(clk), .rst_n(rst_n), .flush(flush), .fetch_ready(fetch_ready),
        .id_valid(id_valid), .id_inst0(id_inst0), .count(u_fetch_buf.count)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // class rule: nop first, then add.w, then addi.w/andi
    function automatic logic [CLS_W-1:0] exp_class(input logic [XLEN-1:0] w);
        if (w == INST_NOP) return CLS_NOP;
        if (w[31:15] == OPC_ADD_W) return CLS_ALU_REG;
        if (w[31:22] == OPC_ADDI_W || w[31:22] == OPC_ANDI) return CLS_ALU_IMM;
        return CLS_OTHER;
    endfunction

    function automatic logic [XLEN-1:0] exp_imm(input logic [XLEN-1:0] w);
        if (exp_class(w) != CLS_ALU_IMM) return '0;
        if (w[31:22] == OPC_ADDI_W) return {{20{w[21]}}, w[21:10]};
        return {20'b0, w[21:10]};  // andi
    endfunction

    task automatic cmp_word(input string what, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic cmp_excp(input string what, input logic [EXCP_W-1:0] exp,
                            input logic [EXCP_W-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic cmp_class(input string what, input logic [CLS_W-1:0] exp,
                             input logic [CLS_W-1:0] act);
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic cmp_rd(input string what, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s: expected r%0d, actual r%0d", cur_test, what, exp, act);
        end
    endtask

    task automatic cmp_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic set_bubble();
        exp_valid = 1'b0;
        exp_pc    = PC_RESET;
        exp_inst0 = INST_NOP;
        exp_inst1 = INST_NOP;
        exp_excp  = '0;
    endtask

    task automatic check_outputs();
        cmp_bit("fetch_ready", exp_ready, fetch_ready);
        cmp_bit("id_valid", exp_valid, id_valid);
        cmp_word("id_pc", exp_pc, id_pc);
        cmp_word("id_inst0", exp_inst0, id_inst0);
        cmp_word("id_inst1", exp_inst1, id_inst1);
        cmp_excp("id_excp", exp_excp, id_excp);
        cmp_class("id_class0", exp_class(exp_inst0), id_class0);
        cmp_class("id_class1", exp_class(exp_inst1), id_class1);
        cmp_rd("id_rd0", exp_inst0[4:0], id_rd0);
        cmp_rd("id_rd1", exp_inst1[4:0], id_rd1);
        cmp_word("id_imm0", exp_imm(exp_inst0), id_imm0);
        cmp_word("id_imm1", exp_imm(exp_inst1), id_imm1);
    endtask

    // called at a falling edge, returns at the next falling edge after checking
    task automatic drive_cycle(input logic v, input logic a, input logic f,
                               input logic [XLEN-1:0] pc, input logic [XLEN-1:0] i0,
                               input logic [XLEN-1:0] i1, input logic [EXCP_W-1:0] ex);
        logic take;
        logic room;
        fetch_valid = v;
        id_allowin  = a;
        flush       = f;
        fetch_pc    = pc;
        fetch_inst0 = i0;
        fetch_inst1 = i1;
        fetch_excp  = ex;
        room = model_q.size() < i_frontend_top.FIFO_DEPTH;
        take = a && !f && model_q.size() != 0;
        if (f) begin
            model_q.delete();
            set_bubble();
        end else if (take) begin
            exp_valid = 1'b1;
            {exp_pc, exp_inst0, exp_inst1, exp_excp} = model_q.pop_front();
        end else if (a) begin
            set_bubble();  // decode takes a bubble from an empty buffer
        end
        if (v && room && !f) model_q.push_back({pc, i0, i1, ex});
        exp_ready = model_q.size() < i_frontend_top.FIFO_DEPTH;
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle(input logic a);
        drive_cycle(1'b0, a, 1'b0, '0, '0, '0, '0);
    endtask

    // wait until the buffer is empty and the register has dropped id_valid
    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((model_q.size() != 0 || id_valid) && n < limit) begin
            idle(1'b1);
            n++;
        end
        if (model_q.size() != 0 || id_valid) begin
            err_count++;
            $display("%s: timed out, decode output still busy after %0d cycles", cur_test, n);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == err_start) begin
            tests_ok++;
            $display("%s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", cur_test, err_count - err_start);
        end
    endtask

    task automatic test_reset();
        begin_test("test_reset");
        check_outputs();
        cmp_class("class0 after reset", CLS_NOP, id_class0);
        end_test();
    endtask

    task automatic test_passthrough();
        begin_test("test_passthrough");
        // add.w r3,r1,r2 / addi.w r4,r5,-8
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000100, 32'h00100823, 32'h02bfe0a4, 7'h00);
        // addi.w r6,r7,100 / andi r8,r9,0xfff
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000108, 32'h028190e6, 32'h037ffd28, 7'h15);
        // unknown opcode / nop
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000110, 32'h50000000, INST_NOP, 7'h40);
        drain(20);
        end_test();
    endtask

    task automatic test_backpressure();
        int writes;
        begin_test("test_backpressure");
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000200, 32'h00100c41, 32'h02800421, 7'h01);
        idle(1'b1);  // packet now held in the register
        writes = 0;
        while (fetch_ready && writes < 4 * i_frontend_top.FIFO_DEPTH) begin
            drive_cycle(1'b1, 1'b0, 1'b0, 32'h1c000208 + 8 * writes, lcg_next(),
                        lcg_next(), 7'(writes + 2));
            writes++;
        end
        if (fetch_ready) begin
            err_count++;
            $display("%s: timed out, fetch_ready never fell", cur_test);
        end
        cmp_word("writes until full", i_frontend_top.FIFO_DEPTH, writes);
        drive_cycle(1'b1, 1'b0, 1'b0, 32'hdeadbeef, '1, '1, '1);  // refused while full
        drain(4 * i_frontend_top.FIFO_DEPTH);
        end_test();
    endtask

    task automatic test_bubble();
        begin_test("test_bubble");
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000300, 32'h02800c63, 32'h00101084, 7'h03);
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000308, 32'h034004a5, 32'h028000c6, 7'h00);
        drain(20);
        cmp_bit("id_valid after drain", 1'b0, id_valid);
        cmp_word("id_pc after drain", PC_RESET, id_pc);
        cmp_word("id_inst1 after drain", INST_NOP, id_inst1);
        end_test();
    endtask

    task automatic test_flush();
        begin_test("test_flush");
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000400, 32'h00100823, 32'h02bfe0a4, 7'h11);
        idle(1'b1);
        drive_cycle(1'b1, 1'b0, 1'b0, 32'h1c000408, 32'h028190e6, 32'h037ffd28, 7'h12);
        drive_cycle(1'b1, 1'b0, 1'b0, 32'h1c000410, 32'h50000000, 32'h00100823, 7'h13);
        drive_cycle(1'b1, 1'b1, 1'b1, 32'h1c000418, 32'h02bfe0a4, 32'h028190e6, 7'h14);
        cmp_bit("id_valid after flush", 1'b0, id_valid);
        cmp_word("id_inst0 after flush", INST_NOP, id_inst0);
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000800, 32'h037ffd28, 32'h00100823, 7'h21);
        drive_cycle(1'b1, 1'b1, 1'b0, 32'h1c000808, 32'h02bfe0a4, 32'h50000000, 7'h22);
        drain(20);
        end_test();
    endtask

    // biased toward the opcodes the predecoder knows
    function automatic logic [XLEN-1:0] rand_inst();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:30])
            2'd0:    return {OPC_ADDI_W, r[21:0]};
            2'd1:    return {OPC_ANDI, r[21:0]};
            2'd2:    return {OPC_ADD_W, r[14:0]};
            default: return r;
        endcase
    endfunction

    task automatic test_random();
        logic [31:0] r;
        begin_test("test_random");
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            // control levels from the upper bits, the low lcg bits repeat quickly
            drive_cycle(r[31], r[30:29] != 2'b00, 1'b0, lcg_next(), rand_inst(), rand_inst(),
                        r[22:16]);
        end
        drain(40);
        end_test();
    endtask

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst0 = '0;
        fetch_inst1 = '0;
        fetch_excp  = '0;
        id_allowin  = 1'b0;
        err_count   = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        exp_ready   = 1'b1;
        set_bubble();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_passthrough();
        test_backpressure();
        test_bubble();
        test_flush();
        test_random();
        $display("done: %0d tests ok, %0d tests with errors, %0d failed checks",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_buf.sv ====
`timescale 1ns/1ps

module fetch_buf import frontend_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              fetch_valid,
    input  logic [XLEN-1:0]   fetch_pc,
    input  logic [XLEN-1:0]   fetch_inst0,
    input  logic [XLEN-1:0]   fetch_inst1,
    input  logic [EXCP_W-1:0] fetch_excp,
    output logic              fetch_ready,
    fetch_id_if.src           bus
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int PKT_W = 3 * XLEN + EXCP_W;

    // packet storage, fields packed as pc, inst0, inst1, excp
    logic [PKT_W-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic wr_en;
    logic rd_en;

    // a write arriving with flush is dropped
    assign wr_en = fetch_valid && fetch_ready && !flush;
    assign rd_en = bus.take;

    assign fetch_ready = (count != CNT_W'(FIFO_DEPTH));
    assign bus.readygo = (count != '0);

    assign {bus.pkt_pc, bus.pkt_inst0, bus.pkt_inst1, bus.pkt_excp} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {fetch_pc, fetch_inst0, fetch_inst1, fetch_excp};
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

endmodule

// ==== verilog/fetch_id_if.sv ====
`timescale 1ns/1ps

interface fetch_id_if import frontend_pkg::*; ();

    // head packet of the fetch buffer
    logic [XLEN-1:0]   pkt_pc;
    logic [XLEN-1:0]   pkt_inst0;
    logic [XLEN-1:0]   pkt_inst1;
    logic [EXCP_W-1:0] pkt_excp;

    logic readygo;  // buffer holds at least one packet
    logic take;     // head is consumed at this edge

    // buffer side
    modport src (
        output pkt_pc,
        output pkt_inst0,
        output pkt_inst1,
        output pkt_excp,
        output readygo,
        input  take
    );

    // decode register side
    modport dst (
        input  pkt_pc,
        input  pkt_inst0,
        input  pkt_inst1,
        input  pkt_excp,
        input  readygo,
        output take
    );

endinterface

// ==== verilog/fifo_id_reg.sv ====
`timescale 1ns/1ps

module fifo_id_reg import frontend_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              id_allowin,
    fetch_id_if.dst           bus,
    output logic              id_valid,
    output logic [XLEN-1:0]   id_pc,
    output logic [XLEN-1:0]   id_inst0,
    output logic [XLEN-1:0]   id_inst1,
    output logic [EXCP_W-1:0] id_excp
);

    logic load_bubble;

    assign bus.take = bus.readygo && id_allowin;

    // decode wants a packet but the buffer has none
    assign load_bubble = id_allowin && !bus.readygo;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_pc    <= PC_RESET;
            id_inst0 <= INST_NOP;
            id_inst1 <= INST_NOP;
            id_excp  <= '0;
        end else if (flush || load_bubble) begin
            id_valid <= 1'b0;
            id_pc    <= PC_RESET;
            id_inst0 <= INST_NOP;
            id_inst1 <= INST_NOP;
            id_excp  <= '0;
        end else if (bus.take) begin
            id_valid <= 1'b1;
            id_pc    <= bus.pkt_pc;
            id_inst0 <= bus.pkt_inst0;
            id_inst1 <= bus.pkt_inst1;
            id_excp  <= bus.pkt_excp;
        end
        // otherwise decode is stalled and the packet stays put
    end

endmodule

// ==== verilog/frontend_pkg.sv ====
package frontend_pkg;

    // datapath widths
    localparam int XLEN   = 32;
    localparam int EXCP_W = 7;

    // values shown while the decode register holds a bubble
    localparam logic [XLEN-1:0] PC_RESET = 32'h1c000000;
    localparam logic [XLEN-1:0] INST_NOP = 32'h03400000;  // andi r0,r0,0

    // major opcodes, one per instruction format
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_ANDI   = 10'h00d;
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;

    // predecode classes handed to the decoder
    localparam int CLS_W = 2;

    localparam logic [CLS_W-1:0] CLS_NOP     = 2'd0;
    localparam logic [CLS_W-1:0] CLS_ALU_REG = 2'd1;  // three-register alu
    localparam logic [CLS_W-1:0] CLS_ALU_IMM = 2'd2;  // register plus 12-bit immediate
    localparam logic [CLS_W-1:0] CLS_OTHER   = 2'd3;

    // one instruction word, two ways of slicing it
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
    } inst_fmt_u;

endpackage

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              fetch_valid,
    input  logic [XLEN-1:0]   fetch_pc,
    input  logic [XLEN-1:0]   fetch_inst0,
    input  logic [XLEN-1:0]   fetch_inst1,
    input  logic [EXCP_W-1:0] fetch_excp,
    input  logic              id_allowin,
    output logic              fetch_ready,
    output logic              id_valid,
    output logic [XLEN-1:0]   id_pc,
    output logic [XLEN-1:0]   id_inst0,
    output logic [XLEN-1:0]   id_inst1,
    output logic [EXCP_W-1:0] id_excp,
    output logic [CLS_W-1:0]  id_class0,
    output logic [CLS_W-1:0]  id_class1,
    output logic [4:0]        id_rd0,
    output logic [4:0]        id_rd1,
    output logic [XLEN-1:0]   id_imm0,
    output logic [XLEN-1:0]   id_imm1
);

    fetch_id_if fid_if ();  // buffer head to decode register

    fetch_buf #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetch_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst0 (fetch_inst0),
        .fetch_inst1 (fetch_inst1),
        .fetch_excp  (fetch_excp),
        .fetch_ready (fetch_ready),
        .bus         (fid_if.src)
    );

    fifo_id_reg u_fifo_id_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .id_allowin (id_allowin),
        .bus        (fid_if.dst),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_inst0   (id_inst0),
        .id_inst1   (id_inst1),
        .id_excp    (id_excp)
    );

    // predecode works on the held words, so results line up with id_valid
    id_predecode u_id_predecode (
        .inst0  (id_inst0),
        .inst1  (id_inst1),
        .class0 (id_class0),
        .class1 (id_class1),
        .rd0    (id_rd0),
        .rd1    (id_rd1),
        .imm0   (id_imm0),
        .imm1   (id_imm1)
    );

endmodule

// ==== verilog/id_predecode.sv ====
`timescale 1ns/1ps

module id_predecode import frontend_pkg::*; (
    input  logic [XLEN-1:0]  inst0,
    input  logic [XLEN-1:0]  inst1,
    output logic [CLS_W-1:0] class0,
    output logic [CLS_W-1:0] class1,
    output logic [4:0]       rd0,
    output logic [4:0]       rd1,
    output logic [XLEN-1:0]  imm0,
    output logic [XLEN-1:0]  imm1
);

    inst_fmt_u w0;
    inst_fmt_u w1;

    assign w0 = inst0;
    assign w1 = inst1;

    // nop is checked first since it is itself a valid andi
    function automatic logic [CLS_W-1:0] inst_class(input inst_fmt_u w);
        logic [CLS_W-1:0] cls;
        if (w == INST_NOP) begin
            cls = CLS_NOP;
        end else if (w.fmt_3r.opcode == OPC_ADD_W) begin
            cls = CLS_ALU_REG;
        end else if (w.fmt_2ri12.opcode == OPC_ADDI_W ||
                     w.fmt_2ri12.opcode == OPC_ANDI) begin
            cls = CLS_ALU_IMM;
        end else begin
            cls = CLS_OTHER;
        end
        return cls;
    endfunction

    // addi.w sign-extends, andi is a logical op and zero-extends
    function automatic logic [XLEN-1:0] inst_imm(input inst_fmt_u w);
        logic [XLEN-1:0] imm;
        logic [11:0]     field;
        field = w.fmt_2ri12.imm;
        imm   = '0;
        if (inst_class(w) == CLS_ALU_IMM) begin
            if (w.fmt_2ri12.opcode == OPC_ADDI_W) begin
                imm = {{(XLEN-12){field[11]}}, field};
            end else begin
                imm = {{(XLEN-12){1'b0}}, field};
            end
        end
        return imm;
    endfunction

    assign class0 = inst_class(w0);
    assign class1 = inst_class(w1);

    // rd sits in the same place in both formats
    assign rd0 = w0.fmt_3r.rd;
    assign rd1 = w1.fmt_3r.rd;

    assign imm0 = inst_imm(w0);
    assign imm1 = inst_imm(w1);

endmodule
